//--- hw/exec_pkg.sv
package exec_pkg;

    localparam int XLEN       = 64;
    localparam int WORD_W     = 32;
    localparam int TAG_W      = 4;

    // multiplier pool, 2 or 8 lanes also work
    localparam int MUL_LANES  = 4;
    localparam int LANE_IDX_W = (MUL_LANES > 1) ? $clog2(MUL_LANES) : 1;

    // radix-4 retires two multiplier bits per step
    localparam int MUL_STEPS  = XLEN / 2;
    localparam int STEP_CNT_W = $clog2(MUL_STEPS + 1);

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_EQ   = 4'd10,
        OP_NE   = 4'd11,
        OP_GE   = 4'd12,
        OP_GEU  = 4'd13,
        OP_MUL  = 4'd14   // goes to the lanes, never to the alu
    } alu_op_t;

    // W-form result, bit 31 copied into the upper half
    function automatic xlen_t sext_word(input word_t w);
        return {{(XLEN - WORD_W){w[WORD_W-1]}}, w};
    endfunction

endpackage

//--- hw/alu_core.sv
module alu_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  exec_pkg::tag_t    in_tag,
    input  exec_pkg::alu_op_t in_op,
    input  logic              in_word,
    input  exec_pkg::xlen_t   in_src1,
    input  exec_pkg::xlen_t   in_src2,
    output logic              alu_valid,
    output exec_pkg::tag_t    alu_tag,
    output exec_pkg::xlen_t   alu_res
);
    import exec_pkg::*;

    word_t      src1_w;
    word_t      src2_w;
    logic [5:0] shamt;     // 64-bit forms, mod 64
    logic [4:0] shamt_w;   // word forms, mod 32
    xlen_t      res_full;
    word_t      res_w;
    logic       is_cmp;
    logic       cmp_hit;
    xlen_t      res_d;
    logic       alu_req;

    assign src1_w  = in_src1[WORD_W-1:0];
    assign src2_w  = in_src2[WORD_W-1:0];
    assign shamt   = in_src2[5:0];
    assign shamt_w = in_src2[4:0];
    assign alu_req = in_valid && (in_op != OP_MUL);

    always_comb begin
        res_full = '0;
        res_w    = '0;
        is_cmp   = 1'b0;
        cmp_hit  = 1'b0;
        case (in_op)
            OP_ADD: begin
                res_full = in_src1 + in_src2;
                res_w    = src1_w + src2_w;
            end
            OP_SUB: begin
                res_full = in_src1 - in_src2;
                res_w    = src1_w - src2_w;
            end
            OP_AND: begin
                res_full = in_src1 & in_src2;
                res_w    = src1_w & src2_w;
            end
            OP_OR: begin
                res_full = in_src1 | in_src2;
                res_w    = src1_w | src2_w;
            end
            OP_XOR: begin
                res_full = in_src1 ^ in_src2;
                res_w    = src1_w ^ src2_w;
            end
            OP_SLL: begin
                res_full = in_src1 << shamt;
                res_w    = src1_w << shamt_w;
            end
            OP_SRL: begin
                res_full = in_src1 >> shamt;
                res_w    = src1_w >> shamt_w;   // zero fill from bit 31
            end
            OP_SRA: begin
                res_full = $signed(in_src1) >>> shamt;
                res_w    = $signed(src1_w) >>> shamt_w;
            end
            OP_SLT: begin
                is_cmp  = 1'b1;
                cmp_hit = $signed(in_src1) < $signed(in_src2);
            end
            OP_SLTU: begin
                is_cmp  = 1'b1;
                cmp_hit = in_src1 < in_src2;
            end
            OP_EQ: begin
                is_cmp  = 1'b1;
                cmp_hit = in_src1 == in_src2;
            end
            OP_NE: begin
                is_cmp  = 1'b1;
                cmp_hit = in_src1 != in_src2;
            end
            OP_GE: begin
                is_cmp  = 1'b1;
                cmp_hit = $signed(in_src1) >= $signed(in_src2);
            end
            OP_GEU: begin
                is_cmp  = 1'b1;
                cmp_hit = in_src1 >= in_src2;
            end
            default: res_full = '0;   // mul handled by the lanes
        endcase

        // compares always give full-width 0/1
        if (is_cmp) begin
            res_d = {{(XLEN - 1){1'b0}}, cmp_hit};
        end else if (in_word) begin
            res_d = sext_word(res_w);
        end else begin
            res_d = res_full;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= alu_req;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_req) begin
            alu_tag <= in_tag;
            alu_res <= res_d;
        end
    end

    // a result only ever follows a non-multiply strobe
    a_valid_follows_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        alu_valid |-> $past(in_valid && (in_op != OP_MUL))
    ) else $error("alu_valid without a preceding alu strobe");

endmodule

//--- hw/mul_dispatch.sv
module mul_dispatch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  exec_pkg::alu_op_t                in_op,
    input  exec_pkg::tag_t                   in_tag,
    input  logic                             in_word,
    input  exec_pkg::xlen_t                  in_src1,
    input  exec_pkg::xlen_t                  in_src2,
    input  logic [exec_pkg::MUL_LANES-1:0]   lane_busy,
    output logic [exec_pkg::MUL_LANES-1:0]   lane_start,
    output exec_pkg::tag_t                   mul_tag,
    output logic                             mul_word,
    output exec_pkg::xlen_t                  mul_src1,
    output exec_pkg::xlen_t                  mul_src2,
    output logic                             mul_full
);
    import exec_pkg::*;

    logic [MUL_LANES-1:0] lane_taken;
    logic [MUL_LANES-1:0] lane_free;
    logic [MUL_LANES-1:0] pick;
    logic                 mul_req;

    // a start issued last cycle has not raised busy yet
    assign lane_taken = lane_busy | lane_start;
    assign lane_free  = ~lane_taken;
    assign mul_full   = &lane_taken;
    assign mul_req    = in_valid && (in_op == OP_MUL);

    // priority search, lowest free lane wins
    always_comb begin
        pick = '0;
        for (int i = MUL_LANES - 1; i >= 0; i--) begin
            if (lane_free[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_start <= '0;
        end else begin
            lane_start <= mul_req ? pick : '0;   // one-hot, one cycle
        end
    end

    // operands shared by all lanes, only the started one latches them
    always_ff @(posedge clk) begin
        if (mul_req) begin
            mul_tag  <= in_tag;
            mul_word <= in_word;
            mul_src1 <= in_src1;
            mul_src2 <= in_src2;
        end
    end

    a_no_mul_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mul_req && mul_full)
    ) else $error("multiply issued while mul_full is high");

endmodule

//--- hw/mul_lane.sv
module mul_lane (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  exec_pkg::tag_t  tag,
    input  logic            word,
    input  exec_pkg::xlen_t src1,
    input  exec_pkg::xlen_t src2,
    input  logic            ack,
    output logic            busy,
    output logic            done,
    output exec_pkg::tag_t  res_tag,
    output exec_pkg::xlen_t res
);
    import exec_pkg::*;

    xlen_t                 mcand;      // shifted left two bits per step
    xlen_t                 mplier;     // shifted right two bits per step
    xlen_t                 acc;
    xlen_t                 partial;
    logic                  word_q;
    logic                  stepping;
    logic                  last_step;
    logic [STEP_CNT_W-1:0] step_cnt;

    assign stepping  = busy && !done;
    assign last_step = (step_cnt == STEP_CNT_W'(MUL_STEPS));
    assign res       = acc;

    // radix-4 digit times multiplicand
    always_comb begin
        case (mplier[1:0])
            2'd0:    partial = '0;
            2'd1:    partial = mcand;
            2'd2:    partial = mcand << 1;
            default: partial = mcand + (mcand << 1);   // 3x
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            done     <= 1'b0;
            step_cnt <= '0;
        end else if (ack) begin
            busy <= 1'b0;   // lane free again
            done <= 1'b0;
        end else if (stepping) begin
            if (last_step) begin
                done <= 1'b1;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // low 64 bits of the product do not depend on operand signedness
    always_ff @(posedge clk) begin
        if (start) begin
            res_tag <= tag;
            word_q  <= word;
            acc     <= '0;
            mcand   <= word ? sext_word(src1[WORD_W-1:0]) : src1;
            mplier  <= word ? sext_word(src2[WORD_W-1:0]) : src2;
        end else if (stepping) begin
            if (last_step) begin
                acc <= word_q ? sext_word(acc[WORD_W-1:0]) : acc;
            end else begin
                acc    <= acc + partial;
                mcand  <= mcand << 2;
                mplier <= mplier >> 2;
            end
        end
    end

    a_ack_only_when_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |-> done
    ) else $error("lane acknowledged without a finished result");

endmodule

//--- hw/result_merge.sv
module result_merge (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      alu_valid,
    input  exec_pkg::tag_t                            alu_tag,
    input  exec_pkg::xlen_t                           alu_res,
    input  logic [exec_pkg::MUL_LANES-1:0]            lane_done,
    input  exec_pkg::tag_t  [exec_pkg::MUL_LANES-1:0] lane_tag,
    input  exec_pkg::xlen_t [exec_pkg::MUL_LANES-1:0] lane_res,
    output logic [exec_pkg::MUL_LANES-1:0]            lane_ack,
    output logic                                      out_valid,
    output exec_pkg::tag_t                            out_tag,
    output exec_pkg::xlen_t                           out_res
);
    import exec_pkg::*;

    lane_idx_t sel_idx;
    logic      lane_any;
    logic      take_lane;

    assign lane_any  = |lane_done;
    assign take_lane = lane_any && !alu_valid;   // alu cannot wait

    // lowest done lane
    always_comb begin
        sel_idx = '0;
        for (int i = MUL_LANES - 1; i >= 0; i--) begin
            if (lane_done[i]) begin
                sel_idx = lane_idx_t'(i);
            end
        end
    end

    always_comb begin
        lane_ack = '0;
        if (take_lane) begin
            lane_ack[sel_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= alu_valid || lane_any;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            out_tag <= alu_tag;
            out_res <= alu_res;
        end else if (lane_any) begin
            out_tag <= lane_tag[sel_idx];
            out_res <= lane_res[sel_idx];
        end
    end

    a_single_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(lane_ack)
    ) else $error("more than one lane acknowledged in a cycle");

endmodule

//--- hw/exec_unit.sv
module exec_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  exec_pkg::tag_t    in_tag,
    input  exec_pkg::alu_op_t in_op,
    input  logic              in_word,
    input  exec_pkg::xlen_t   in_src1,
    input  exec_pkg::xlen_t   in_src2,
    output logic              mul_full,
    output logic              out_valid,
    output exec_pkg::tag_t    out_tag,
    output exec_pkg::xlen_t   out_res
);
    import exec_pkg::*;

    logic                   alu_valid;
    tag_t                   alu_tag;
    xlen_t                  alu_res;

    logic [MUL_LANES-1:0]   lane_start;
    logic [MUL_LANES-1:0]   lane_busy;
    logic [MUL_LANES-1:0]   lane_done;
    logic [MUL_LANES-1:0]   lane_ack;
    tag_t                   mul_tag;
    logic                   mul_word;
    xlen_t                  mul_src1;
    xlen_t                  mul_src2;
    tag_t  [MUL_LANES-1:0]  lane_tag;
    xlen_t [MUL_LANES-1:0]  lane_res;

    alu_core u_alu (
        .clk, .rst_n, .in_valid, .in_tag, .in_op, .in_word, .in_src1, .in_src2,
        .alu_valid, .alu_tag, .alu_res
    );

    mul_dispatch u_dispatch (
        .clk, .rst_n, .in_valid, .in_op, .in_tag, .in_word, .in_src1, .in_src2,
        .lane_busy, .lane_start, .mul_tag, .mul_word, .mul_src1, .mul_src2, .mul_full
    );

    for (genvar g = 0; g < MUL_LANES; g++) begin : g_lane
        mul_lane u_lane (
            .clk, .rst_n,
            .start   (lane_start[g]),
            .tag     (mul_tag),
            .word    (mul_word),
            .src1    (mul_src1),
            .src2    (mul_src2),
            .ack     (lane_ack[g]),
            .busy    (lane_busy[g]),
            .done    (lane_done[g]),
            .res_tag (lane_tag[g]),
            .res     (lane_res[g])
        );
    end

    result_merge u_merge (
        .clk, .rst_n, .alu_valid, .alu_tag, .alu_res,
        .lane_done, .lane_tag, .lane_res, .lane_ack,
        .out_valid, .out_tag, .out_res
    );

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 20;   // 40 ns period

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- testbench/tb_exec_unit.sv
module tb_exec_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import exec_pkg::*;

    localparam int MAX_CASES    = 32;
    localparam int NUM_TAGS     = 2 ** TAG_W;
    localparam int RESET_CYCLES = 4;
    localparam int MUL_MIN_LAT  = 34;
    localparam int MUL_MAX_LAT  = 60;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    tag_t    in_tag;
    alu_op_t in_op;
    logic    in_word;
    xlen_t   in_src1;
    xlen_t   in_src2;
    logic    mul_full;
    logic    out_valid;
    tag_t    out_tag;
    xlen_t   out_res;

    tag_t       case_tag  [MAX_CASES];
    logic [3:0] case_op   [MAX_CASES];
    logic       case_word [MAX_CASES];
    xlen_t      case_src1 [MAX_CASES];
    xlen_t      case_src2 [MAX_CASES];
    xlen_t      case_exp  [MAX_CASES];
    int         n_cases;

    // scoreboard indexed by tag
    logic  pending     [NUM_TAGS];
    logic  tag_used    [NUM_TAGS];
    logic  tag_is_mul  [NUM_TAGS];
    xlen_t exp_res     [NUM_TAGS];
    int    issue_cycle [NUM_TAGS];

    int     cycle;
    int     retired;
    int     mul_outstanding;
    int     next_case;
    int     gap;         // idle cycles left before the next strobe
    int     limit;
    integer seed;
    integer rnd;

    tb_clock u_clk (.clk(clk));

    exec_unit u_dut (
        .clk, .rst_n, .in_valid, .in_tag, .in_op, .in_word, .in_src1, .in_src2,
        .mul_full, .out_valid, .out_tag, .out_res
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input xlen_t actual, input xlen_t expected, input string what);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch at time %0t: %s, got %h expected %h",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic read_cases();
        integer         fd;
        integer         code;
        reg [8*200-1:0] line;
        logic [3:0]     t;
        logic [3:0]     o;
        logic [3:0]     w;
        xlen_t          s1;
        xlen_t          s2;
        xlen_t          ex;
        fd = $fopen("testbench/exec_cases.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the case file testbench/exec_cases.txt");
        end
        n_cases = 0;
        while (!$feof(fd)) begin
            line = '0;
            code = $fgets(line, fd);
            if (code > 0) begin
                code = $sscanf(line, "%h %h %h %h %h %h", t, o, w, s1, s2, ex);
                if (code == 6) begin   // comment lines give no match
                    if (n_cases == MAX_CASES) begin
                        stop_with_error("too many cases in the case file");
                    end
                    case_tag[n_cases]  = t;
                    case_op[n_cases]   = o;
                    case_word[n_cases] = w[0];
                    case_src1[n_cases] = s1;
                    case_src2[n_cases] = s2;
                    case_exp[n_cases]  = ex;
                    tag_used[t]        = 1'b1;
                    n_cases++;
                end
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            stop_with_error("no cases were read from the case file");
        end
    endtask

    // tag must be free and a multiply needs a lane
    function automatic logic can_issue(input int idx);
        logic is_mul;
        is_mul = (alu_op_t'(case_op[idx]) == OP_MUL);
        return !pending[case_tag[idx]] && !(is_mul && mul_full);
    endfunction

    task automatic issue_case(input int idx);
        tag_t t;
        t = case_tag[idx];
        in_valid = 1'b1;
        in_tag   = t;
        in_op    = alu_op_t'(case_op[idx]);
        in_word  = case_word[idx];
        in_src1  = case_src1[idx];
        in_src2  = case_src2[idx];
        pending[t]     = 1'b1;
        exp_res[t]     = case_exp[idx];
        issue_cycle[t] = cycle;
        tag_is_mul[t]  = (alu_op_t'(case_op[idx]) == OP_MUL);
        if (tag_is_mul[t]) begin
            mul_outstanding++;
        end
    endtask

    task automatic retire_result();
        tag_t t;
        int   lat;
        t = out_tag;
        if ($isunknown(t) || !tag_used[t]) begin
            stop_with_error($sformatf("result arrived with unknown tag %0d", t));
        end
        if (!pending[t]) begin
            stop_with_error($sformatf("duplicate result for tag %0d", t));
        end
        lat = cycle - issue_cycle[t];
        check_value(out_res, exp_res[t], $sformatf("result of tag %0d", t));
        if (tag_is_mul[t]) begin
            if (lat < MUL_MIN_LAT || lat > MUL_MAX_LAT) begin
                stop_with_error($sformatf("multiply tag %0d took %0d cycles", t, lat));
            end
            mul_outstanding--;
        end else begin
            check_value(xlen_t'(lat), xlen_t'(2), $sformatf("alu latency of tag %0d", t));
        end
        pending[t] = 1'b0;
        retired++;
    endtask

    initial begin
        seed     = 62888;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_tag   = '0;
        in_op    = OP_ADD;
        in_word  = 1'b0;
        in_src1  = '0;
        in_src2  = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            pending[i]     = 1'b0;
            tag_used[i]    = 1'b0;
            tag_is_mul[i]  = 1'b0;
            exp_res[i]     = '0;
            issue_cycle[i] = 0;
        end
        cycle           = 0;
        retired         = 0;
        mul_outstanding = 0;
        next_case       = 0;
        gap             = 0;
        read_cases();
        limit = n_cases * 40 + 200;

        @(posedge clk);   // first rising edge applies the reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value(xlen_t'(out_valid), '0, "out_valid during reset");
            check_value(xlen_t'(mul_full), '0, "mul_full during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value(xlen_t'(out_valid), '0, "out_valid right after reset");
        check_value(xlen_t'(mul_full), '0, "mul_full right after reset");

        while (retired < n_cases) begin
            @(negedge clk);
            cycle++;
            if (cycle > limit) begin
                stop_with_error("timeout waiting for results");
            end
            if (mul_full && (mul_outstanding < MUL_LANES)) begin
                stop_with_error($sformatf("mul_full high with only %0d multiplies outstanding",
                                          mul_outstanding));
            end
            if (out_valid) begin
                retire_result();
            end
            in_valid = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (next_case < n_cases && can_issue(next_case)) begin
                issue_case(next_case);
                next_case++;
                rnd = $random(seed);
                gap = rnd & 3;   // 0 to 3 idle cycles
            end
        end

        // nothing more may come out
        repeat (4) begin
            @(negedge clk);
            if (out_valid) begin
                retire_result();
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- build.f
hw/exec_pkg.sv
hw/alu_core.sv
hw/mul_dispatch.sv
hw/mul_lane.sv
hw/result_merge.sv
hw/exec_unit.sv
testbench/tb_clock.sv
testbench/tb_exec_unit.sv

//--- testbench/exec_cases.txt
# columns: tag op word src1 src2 expected, all in hex
# op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu a eq b ne c ge d geu e mul
0 e 0 0000000000000003 0000000000000007 0000000000000015
1 0 0 7fffffffffffffff 0000000000000001 8000000000000000
2 e 0 ffffffffffffffff 0000000000000005 fffffffffffffffb
3 e 1 deadbeef40000000 0000000000000002 ffffffff80000000
4 1 0 0000000000000000 0000000000000001 ffffffffffffffff
5 e 0 00000000ffffffff 00000000ffffffff fffffffe00000001
6 e 1 00000000ffffffff 0000000000000003 fffffffffffffffd
7 2 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000
8 4 0 aaaaaaaaaaaaaaaa ffffffffffffffff 5555555555555555
9 5 0 0000000000000001 000000000000003f 8000000000000000
a 6 0 8000000000000000 0000000000000041 4000000000000000
b 7 0 8000000000000000 000000000000007f ffffffffffffffff
c 8 0 ffffffffffffffff 0000000000000001 0000000000000001
d 9 0 ffffffffffffffff 0000000000000001 0000000000000000
e c 0 8000000000000000 0000000000000000 0000000000000000
f d 0 8000000000000000 0000000000000000 0000000000000001
1 3 0 00000000000000f0 000000000000000f 00000000000000ff
4 a 0 123456789abcdef0 123456789abcdef0 0000000000000001
7 b 0 123456789abcdef0 123456789abcdef1 0000000000000001
8 0 1 000000007fffffff 0000000000000001 ffffffff80000000
9 7 1 0000000080000000 0000000000000024 fffffffff8000000
a 6 1 ffffffff80000000 000000000000001f 0000000000000001
